// File: source/pcie_datalink_pkg.sv
package pcie_datalink_pkg;

  localparam int DATA_WIDTH    = 32;
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
  localparam int USER_WIDTH    = 4;  // Bit 0 is the PHY error flag
  localparam int S_COUNT       = 2;
  localparam int M_COUNT       = 2;
  localparam int RX_FIFO_DEPTH = 64;

  localparam logic [15:0] DLLP_CRC_POLY = 16'h100B;
  localparam logic [15:0] DLLP_CRC_INIT = 16'hFFFF;
  localparam logic [31:0] LCRC_POLY     = 32'h04C1_1DB7;
  localparam logic [31:0] LCRC_INIT     = 32'hFFFF_FFFF;

  typedef enum logic [1:0] {
    DL_INACTIVE,
    DL_INIT,
    DL_ACTIVE
  } pcie_dl_status_e;

  typedef enum logic [7:0] {
    DLLP_ACK         = 8'h00,
    DLLP_NAK         = 8'h10,
    DLLP_INITFC1_P   = 8'h40,
    DLLP_INITFC1_NP  = 8'h50,
    DLLP_INITFC2_P   = 8'hC0,
    DLLP_INITFC2_NP  = 8'hD0,
    DLLP_UPDATEFC_P  = 8'h80,
    DLLP_UPDATEFC_NP = 8'h90
  } dllp_type_e;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tlast;
    logic [USER_WIDTH-1:0] tuser;
  } axis_beat_t;

  typedef struct packed {
    logic [7:0]  hdr;
    logic [11:0] data;
  } fc_credit_t;

  // MSB first over the 32-bit DLLP word
  function automatic logic [15:0] dllp_crc16(input logic [31:0] word);
    logic [15:0] crc;
    logic        fb;
    crc = DLLP_CRC_INIT;
    for (int i = 31; i >= 0; i--) begin
      fb  = crc[15] ^ word[i];
      crc = {crc[14:0], 1'b0} ^ (fb ? DLLP_CRC_POLY : 16'h0000);
    end
    return ~crc;
  endfunction

  // One word of LCRC, MSB first; caller seeds with LCRC_INIT and inverts the final value
  function automatic logic [31:0] lcrc_next(input logic [31:0] crc_in,
                                            input logic [31:0] word);
    logic [31:0] crc;
    logic        fb;
    crc = crc_in;
    for (int i = 31; i >= 0; i--) begin
      fb  = crc[31] ^ word[i];
      crc = {crc[30:0], 1'b0} ^ (fb ? LCRC_POLY : 32'h0000_0000);
    end
    return crc;
  endfunction

endpackage

// File: source/rx_tlp_fifo.sv
module rx_tlp_fifo #(
  parameter int DEPTH = pcie_datalink_pkg::RX_FIFO_DEPTH
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  pcie_datalink_pkg::axis_beat_t wr_beat_i,
  input  logic                          wr_en_i,
  input  logic                          commit_i,
  input  logic                          drop_i,
  input  logic                          rd_ready_i,
  output logic                          full_o,
  output logic                          overflow_o,
  output pcie_datalink_pkg::axis_beat_t rd_beat_o,
  output logic                          rd_valid_o
);

  pcie_datalink_pkg::axis_beat_t mem [DEPTH];
  logic [$clog2(DEPTH):0]        wr_ptr;
  logic [$clog2(DEPTH):0]        cmt_ptr;  // End of the last committed frame
  logic [$clog2(DEPTH):0]        rd_ptr;
  logic [$clog2(DEPTH):0]        wr_ptr_nxt;
  logic [$clog2(DEPTH):0]        used;
  logic                          no_room;
  logic                          ovf_q;
  logic                          wr_ok;
  logic                          fetch;

  assign used    = wr_ptr - rd_ptr;
  assign no_room = used == DEPTH;
  // Stall only when draining committed beats will free space
  assign full_o     = no_room && (cmt_ptr != rd_ptr);
  assign overflow_o = ovf_q || (wr_en_i && no_room);

  assign wr_ok      = wr_en_i && !no_room && !ovf_q;
  assign wr_ptr_nxt = wr_ptr + wr_ok;
  assign fetch      = (cmt_ptr != rd_ptr) && (!rd_valid_o || rd_ready_i);

  always_ff @(posedge clk_i) begin
    if (wr_ok) begin
      mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wr_beat_i;
    end
    if (fetch) begin
      rd_beat_o <= mem[rd_ptr[$clog2(DEPTH)-1:0]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr     <= '0;
      cmt_ptr    <= '0;
      rd_ptr     <= '0;
      ovf_q      <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      wr_ptr <= drop_i ? cmt_ptr : wr_ptr_nxt;  // Drop rewinds to the last commit
      if (commit_i) begin
        cmt_ptr <= wr_ptr_nxt;
      end
      if (commit_i || drop_i) begin
        ovf_q <= 1'b0;
      end else if (wr_en_i && no_room) begin
        ovf_q <= 1'b1;
      end
      if (fetch) begin
        rd_ptr     <= rd_ptr + 1'b1;
        rd_valid_o <= 1'b1;
      end else if (rd_ready_i) begin
        rd_valid_o <= 1'b0;
      end
    end
  end

endmodule

// File: source/dllp_handler.sv
module dllp_handler (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          phy_link_up_i,
  input  pcie_datalink_pkg::axis_beat_t s_beat_i,
  input  logic                          s_valid_i,
  output logic                          s_ready_o,
  output logic [11:0]                   seq_num_o,
  output logic                          seq_num_vld_o,
  output logic                          seq_num_acknack_o,
  output logic                          fc1_values_stored_o,
  output logic                          fc2_values_stored_o,
  output pcie_datalink_pkg::fc_credit_t tx_fc_p_o,
  output pcie_datalink_pkg::fc_credit_t tx_fc_np_o
);

  logic [31:0]                   dllp_word;  // Beat 0 of the frame
  logic                          word_vld;
  logic                          ready_q;
  logic                          accept;
  logic                          crc_ok;
  logic [1:0]                    fc1_seen;   // {np, p}
  logic [1:0]                    fc2_seen;
  pcie_datalink_pkg::dllp_type_e dllp_type;
  pcie_datalink_pkg::fc_credit_t credit;

  assign s_ready_o = ready_q;
  assign accept    = s_valid_i && ready_q;
  assign crc_ok    = s_beat_i.tdata[15:0] == pcie_datalink_pkg::dllp_crc16(dllp_word);
  assign dllp_type = pcie_datalink_pkg::dllp_type_e'(dllp_word[31:24]);
  assign credit    = dllp_word[19:0];

  assign fc1_values_stored_o = &fc1_seen;
  assign fc2_values_stored_o = &fc2_seen;

  always_ff @(posedge clk_i) begin
    if (accept && !s_beat_i.tlast) begin
      dllp_word <= s_beat_i.tdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q           <= 1'b0;
      word_vld          <= 1'b0;
      seq_num_o         <= '0;
      seq_num_vld_o     <= 1'b0;
      seq_num_acknack_o <= 1'b0;
      fc1_seen          <= '0;
      fc2_seen          <= '0;
      tx_fc_p_o         <= '0;
      tx_fc_np_o        <= '0;
    end else begin
      ready_q       <= 1'b1;
      seq_num_vld_o <= 1'b0;
      if (!phy_link_up_i) begin
        word_vld <= 1'b0;  // Link down drops any half frame
      end else if (accept) begin
        word_vld <= !s_beat_i.tlast;
        if (s_beat_i.tlast && word_vld && crc_ok) begin
          case (dllp_type)
            pcie_datalink_pkg::DLLP_ACK, pcie_datalink_pkg::DLLP_NAK: begin
              seq_num_o         <= dllp_word[11:0];
              seq_num_acknack_o <= dllp_type == pcie_datalink_pkg::DLLP_ACK;
              seq_num_vld_o     <= 1'b1;
            end
            pcie_datalink_pkg::DLLP_INITFC1_P: begin
              tx_fc_p_o   <= credit;
              fc1_seen[0] <= 1'b1;
            end
            pcie_datalink_pkg::DLLP_INITFC1_NP: begin
              tx_fc_np_o  <= credit;
              fc1_seen[1] <= 1'b1;
            end
            pcie_datalink_pkg::DLLP_INITFC2_P: begin
              tx_fc_p_o   <= credit;
              fc2_seen[0] <= 1'b1;
            end
            pcie_datalink_pkg::DLLP_INITFC2_NP: begin
              tx_fc_np_o  <= credit;
              fc2_seen[1] <= 1'b1;
            end
            pcie_datalink_pkg::DLLP_UPDATEFC_P:  tx_fc_p_o  <= credit;
            pcie_datalink_pkg::DLLP_UPDATEFC_NP: tx_fc_np_o <= credit;
            default: ;  // Unknown type
          endcase
        end
      end
    end
  end

endmodule

// File: source/dllp2tlp.sv
module dllp2tlp (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  pcie_datalink_pkg::pcie_dl_status_e link_status_i,
  input  pcie_datalink_pkg::axis_beat_t      s_beat_i,
  input  logic                               s_valid_i,
  input  logic                               phy_ready_i,
  input  logic                               tlp_ready_i,
  output logic                               s_ready_o,
  output pcie_datalink_pkg::axis_beat_t      phy_beat_o,
  output logic                               phy_valid_o,
  output pcie_datalink_pkg::axis_beat_t      tlp_beat_o,
  output logic                               tlp_valid_o
);

  typedef enum logic {
    RX_SEQ,
    RX_DATA
  } rx_state_e;

  rx_state_e                     state;
  pcie_datalink_pkg::axis_beat_t hold_beat;  // Payload beat waiting for its successor
  pcie_datalink_pkg::axis_beat_t wr_beat;
  logic                          hold_vld;
  logic                          err_q;
  logic [11:0]                   rx_seq;
  logic [11:0]                   exp_seq;
  logic [11:0]                   seq_diff;
  logic [31:0]                   crc_q;
  logic [31:0]                   crc_fin;
  logic                          accept;
  logic                          last_acc;
  logic                          wr_en;
  logic                          commit;
  logic                          drop;
  logic                          fifo_full;
  logic                          fifo_ovf;
  logic                          frame_bad;
  logic                          seq_ok;
  logic                          dup;
  logic                          link_active;
  logic                          ack_vld;
  logic                          ack_beat1;
  pcie_datalink_pkg::dllp_type_e ack_type;
  logic [11:0]                   ack_seq;
  logic [31:0]                   ack_word;

  assign s_ready_o   = !ack_vld && !fifo_full;
  assign accept      = s_valid_i && s_ready_o;
  assign last_acc    = accept && state == RX_DATA && s_beat_i.tlast;
  assign wr_en       = accept && state == RX_DATA && hold_vld;
  assign link_active = link_status_i == pcie_datalink_pkg::DL_ACTIVE;

  // Held beat becomes the final payload beat when the LCRC arrives
  assign wr_beat = '{tdata: hold_beat.tdata, tkeep: hold_beat.tkeep,
                     tlast: s_beat_i.tlast, tuser: hold_beat.tuser};
  assign crc_fin = hold_vld ? pcie_datalink_pkg::lcrc_next(crc_q, hold_beat.tdata) : crc_q;

  assign frame_bad = err_q || s_beat_i.tuser[0] || fifo_ovf ||
                     ((~crc_fin) != s_beat_i.tdata);
  assign seq_diff  = exp_seq - rx_seq;
  assign seq_ok    = seq_diff == 12'd0;
  assign dup       = !seq_ok && seq_diff <= 12'd2048;
  assign commit    = last_acc && link_active && seq_ok && !frame_bad;
  assign drop      = last_acc && !commit;

  assign ack_word    = {ack_type, 12'h000, ack_seq};
  assign phy_valid_o = ack_vld;
  assign phy_beat_o  = ack_beat1 ?
      pcie_datalink_pkg::axis_beat_t'{tdata: {16'h0000, pcie_datalink_pkg::dllp_crc16(ack_word)},
                                      tkeep: 4'b0011, tlast: 1'b1, tuser: '0} :
      pcie_datalink_pkg::axis_beat_t'{tdata: ack_word, tkeep: 4'b1111, tlast: 1'b0, tuser: '0};

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (state == RX_SEQ) begin
        rx_seq <= s_beat_i.tdata[11:0];
        crc_q  <= pcie_datalink_pkg::lcrc_next(pcie_datalink_pkg::LCRC_INIT, s_beat_i.tdata);
      end else if (!s_beat_i.tlast) begin
        hold_beat <= s_beat_i;
        crc_q     <= crc_fin;
      end
    end
    if (last_acc) begin
      if (seq_ok && !frame_bad) begin
        ack_type <= pcie_datalink_pkg::DLLP_ACK;
        ack_seq  <= rx_seq;
      end else begin
        ack_type <= (!frame_bad && dup) ? pcie_datalink_pkg::DLLP_ACK :
                                          pcie_datalink_pkg::DLLP_NAK;
        ack_seq  <= exp_seq - 12'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state     <= RX_SEQ;
      hold_vld  <= 1'b0;
      err_q     <= 1'b0;
      exp_seq   <= '0;
      ack_vld   <= 1'b0;
      ack_beat1 <= 1'b0;
    end else begin
      if (ack_vld && phy_ready_i) begin
        ack_beat1 <= !ack_beat1;
        if (ack_beat1) begin
          ack_vld <= 1'b0;
        end
      end
      if (accept) begin
        case (state)
          RX_SEQ: begin
            err_q <= s_beat_i.tuser[0];
            if (!s_beat_i.tlast) begin
              state <= RX_DATA;  // A lone beat is a runt and is skipped
            end
          end
          RX_DATA: begin
            err_q    <= err_q | s_beat_i.tuser[0];
            hold_vld <= !s_beat_i.tlast;
            if (s_beat_i.tlast) begin
              state <= RX_SEQ;
              if (link_active) begin
                ack_vld   <= 1'b1;
                ack_beat1 <= 1'b0;
              end
              if (commit) begin
                exp_seq <= exp_seq + 12'd1;
              end
            end
          end
          default: state <= RX_SEQ;
        endcase
      end
    end
  end

  rx_tlp_fifo #(
    .DEPTH(pcie_datalink_pkg::RX_FIFO_DEPTH)
  ) rx_tlp_fifo_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_beat_i (wr_beat),
    .wr_en_i   (wr_en),
    .commit_i  (commit),
    .drop_i    (drop),
    .rd_ready_i(tlp_ready_i),
    .full_o    (fifo_full),
    .overflow_o(fifo_ovf),
    .rd_beat_o (tlp_beat_o),
    .rd_valid_o(tlp_valid_o)
  );

endmodule

// File: source/dllp_recieve.sv
module dllp_recieve (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  pcie_datalink_pkg::pcie_dl_status_e link_status_i,
  input  logic                               phy_link_up_i,

  input  logic [pcie_datalink_pkg::S_COUNT*pcie_datalink_pkg::DATA_WIDTH-1:0] s_axis_tdata_i,
  input  logic [pcie_datalink_pkg::S_COUNT*pcie_datalink_pkg::KEEP_WIDTH-1:0] s_axis_tkeep_i,
  input  logic [pcie_datalink_pkg::S_COUNT-1:0]                               s_axis_tvalid_i,
  input  logic [pcie_datalink_pkg::S_COUNT-1:0]                               s_axis_tlast_i,
  input  logic [pcie_datalink_pkg::S_COUNT*pcie_datalink_pkg::USER_WIDTH-1:0] s_axis_tuser_i,
  output logic [pcie_datalink_pkg::S_COUNT-1:0]                               s_axis_tready_o,

  output logic [pcie_datalink_pkg::M_COUNT*pcie_datalink_pkg::DATA_WIDTH-1:0] m_axis_tdata_o,
  output logic [pcie_datalink_pkg::M_COUNT*pcie_datalink_pkg::KEEP_WIDTH-1:0] m_axis_tkeep_o,
  output logic [pcie_datalink_pkg::M_COUNT-1:0]                               m_axis_tvalid_o,
  output logic [pcie_datalink_pkg::M_COUNT-1:0]                               m_axis_tlast_o,
  output logic [pcie_datalink_pkg::M_COUNT*pcie_datalink_pkg::USER_WIDTH-1:0] m_axis_tuser_o,
  input  logic [pcie_datalink_pkg::M_COUNT-1:0]                               m_axis_tready_i,

  output logic [11:0] seq_num_o,
  output logic        seq_num_vld_o,
  output logic        seq_num_acknack_o,
  output logic        fc1_values_stored_o,
  output logic        fc2_values_stored_o,
  output logic [7:0]  tx_fc_ph_o,
  output logic [11:0] tx_fc_pd_o,
  output logic [7:0]  tx_fc_nph_o,
  output logic [11:0] tx_fc_npd_o
);

  pcie_datalink_pkg::axis_beat_t s_beat [pcie_datalink_pkg::S_COUNT];  // 0 DLLP, 1 TLP
  pcie_datalink_pkg::axis_beat_t m_beat [pcie_datalink_pkg::M_COUNT];  // 0 Ack/Nak, 1 TLP
  pcie_datalink_pkg::fc_credit_t tx_fc_p;
  pcie_datalink_pkg::fc_credit_t tx_fc_np;

  for (genvar i = 0; i < pcie_datalink_pkg::S_COUNT; i++) begin : g_s_lane
    assign s_beat[i].tdata = s_axis_tdata_i[i*pcie_datalink_pkg::DATA_WIDTH +:
                                            pcie_datalink_pkg::DATA_WIDTH];
    assign s_beat[i].tkeep = s_axis_tkeep_i[i*pcie_datalink_pkg::KEEP_WIDTH +:
                                            pcie_datalink_pkg::KEEP_WIDTH];
    assign s_beat[i].tlast = s_axis_tlast_i[i];
    assign s_beat[i].tuser = s_axis_tuser_i[i*pcie_datalink_pkg::USER_WIDTH +:
                                            pcie_datalink_pkg::USER_WIDTH];
  end

  for (genvar i = 0; i < pcie_datalink_pkg::M_COUNT; i++) begin : g_m_lane
    assign m_axis_tdata_o[i*pcie_datalink_pkg::DATA_WIDTH +: pcie_datalink_pkg::DATA_WIDTH] =
        m_beat[i].tdata;
    assign m_axis_tkeep_o[i*pcie_datalink_pkg::KEEP_WIDTH +: pcie_datalink_pkg::KEEP_WIDTH] =
        m_beat[i].tkeep;
    assign m_axis_tlast_o[i] = m_beat[i].tlast;
    assign m_axis_tuser_o[i*pcie_datalink_pkg::USER_WIDTH +: pcie_datalink_pkg::USER_WIDTH] =
        m_beat[i].tuser;
  end

  assign tx_fc_ph_o  = tx_fc_p.hdr;
  assign tx_fc_pd_o  = tx_fc_p.data;
  assign tx_fc_nph_o = tx_fc_np.hdr;
  assign tx_fc_npd_o = tx_fc_np.data;

  dllp_handler dllp_handler_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .phy_link_up_i      (phy_link_up_i),
    .s_beat_i           (s_beat[0]),
    .s_valid_i          (s_axis_tvalid_i[0]),
    .s_ready_o          (s_axis_tready_o[0]),
    .seq_num_o          (seq_num_o),
    .seq_num_vld_o      (seq_num_vld_o),
    .seq_num_acknack_o  (seq_num_acknack_o),
    .fc1_values_stored_o(fc1_values_stored_o),
    .fc2_values_stored_o(fc2_values_stored_o),
    .tx_fc_p_o          (tx_fc_p),
    .tx_fc_np_o         (tx_fc_np)
  );

  dllp2tlp dllp2tlp_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_status_i(link_status_i),
    .s_beat_i     (s_beat[1]),
    .s_valid_i    (s_axis_tvalid_i[1]),
    .phy_ready_i  (m_axis_tready_i[0]),
    .tlp_ready_i  (m_axis_tready_i[1]),
    .s_ready_o    (s_axis_tready_o[1]),
    .phy_beat_o   (m_beat[0]),
    .phy_valid_o  (m_axis_tvalid_o[0]),
    .tlp_beat_o   (m_beat[1]),
    .tlp_valid_o  (m_axis_tvalid_o[1])
  );

endmodule

// File: include/tb_dllp_ref.svh
`ifndef TB_DLLP_REF_SVH
`define TB_DLLP_REF_SVH

// Bit-serial DLLP CRC16, word MSB first
function automatic logic [15:0] crc16_ref(input logic [31:0] word);
  logic [15:0] r;
  r = 16'hFFFF;
  for (int b = 31; b >= 0; b--) begin
    if (r[15] ^ word[b]) begin
      r = (r << 1) ^ 16'h100B;
    end else begin
      r = r << 1;
    end
  end
  return ~r;
endfunction

// Folds one word into a running LCRC; the frame value is the inverse of the last result
function automatic logic [31:0] crc32_ref(input logic [31:0] r_in, input logic [31:0] word);
  logic [31:0] r;
  r = r_in;
  for (int b = 31; b >= 0; b--) begin
    if (r[31] ^ word[b]) begin
      r = (r << 1) ^ 32'h04C1_1DB7;
    end else begin
      r = r << 1;
    end
  end
  return r;
endfunction

// Reply to a received TLP as {ack, seq, commit}
function automatic logic [13:0] tlp_reply(input logic [11:0] seq, input logic [11:0] expected,
                                          input logic bad);
  logic [11:0] behind;
  behind = expected - seq;
  if (!bad && behind == 12'd0) begin
    return {1'b1, seq, 1'b1};
  end
  if (!bad && behind <= 12'd2048) begin
    return {1'b1, expected - 12'd1, 1'b0};  // Duplicate
  end
  return {1'b0, expected - 12'd1, 1'b0};
endfunction

// Both beats of an Ack/Nak DLLP on output lane 0
function automatic void expect_dllp(input logic [7:0] typ, input logic [11:0] seq);
  logic [31:0] word;
  word = {typ, 12'h000, seq};
  ack_q.push_back({1'b0, 4'b1111, 4'h0, word});
  ack_q.push_back({1'b1, 4'b0011, 4'h0, 16'h0000, crc16_ref(word)});
endfunction

// Effect of a good DLLP on input lane 0
function automatic void apply_dllp(input logic [31:0] word);
  case (word[31:24])
    8'h00: seq_q.push_back({1'b1, word[11:0]});
    8'h10: seq_q.push_back({1'b0, word[11:0]});
    8'h40: begin
      fc_p        = word[19:0];
      fc1_seen[0] = 1'b1;
    end
    8'h50: begin
      fc_np       = word[19:0];
      fc1_seen[1] = 1'b1;
    end
    8'hC0: begin
      fc_p        = word[19:0];
      fc2_seen[0] = 1'b1;
    end
    8'hD0: begin
      fc_np       = word[19:0];
      fc2_seen[1] = 1'b1;
    end
    8'h80: fc_p = word[19:0];
    8'h90: fc_np = word[19:0];
    default: ;
  endcase
endfunction

`endif

// File: test/tb_dllp_recieve.sv
module tb_dllp_recieve;

  localparam int N_GOOD     = 12;
  localparam int N_ACKNAK   = 6;
  localparam int NUM_FRAMES = N_GOOD + 5 + N_ACKNAK + N_ACKNAK / 2 + 8 + 3;
  localparam int K_GOOD     = 0;
  localparam int K_BADCRC   = 1;
  localparam int K_PHYERR   = 2;

  logic                               clk_i;
  logic                               rst_i;
  pcie_datalink_pkg::pcie_dl_status_e link_status_i;
  logic                               phy_link_up_i;
  logic [63:0]                        s_axis_tdata_i;
  logic [7:0]                         s_axis_tkeep_i;
  logic [1:0]                         s_axis_tvalid_i;
  logic [1:0]                         s_axis_tlast_i;
  logic [7:0]                         s_axis_tuser_i;
  logic [1:0]                         s_axis_tready_o;
  logic [63:0]                        m_axis_tdata_o;
  logic [7:0]                         m_axis_tkeep_o;
  logic [1:0]                         m_axis_tvalid_o;
  logic [1:0]                         m_axis_tlast_o;
  logic [7:0]                         m_axis_tuser_o;
  logic [1:0]                         m_axis_tready_i;
  logic [11:0]                        seq_num_o;
  logic                               seq_num_vld_o;
  logic                               seq_num_acknack_o;
  logic                               fc1_values_stored_o;
  logic                               fc2_values_stored_o;
  logic [7:0]                         tx_fc_ph_o;
  logic [11:0]                        tx_fc_pd_o;
  logic [7:0]                         tx_fc_nph_o;
  logic [11:0]                        tx_fc_npd_o;

  logic [40:0] ack_q[$];  // {tlast, tkeep, tuser, tdata}
  logic [40:0] tlp_q[$];
  logic [12:0] seq_q[$];  // {acknack, seq_num}
  logic [11:0] model_seq;
  logic [19:0] fc_p;
  logic [19:0] fc_np;
  logic [1:0]  fc1_seen;
  logic [1:0]  fc2_seen;
  logic [31:0] stim_seed;
  logic [31:0] rdy_seed;
  int          errors;

  `include "tb_dllp_ref.svh"

  dllp_recieve dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  function automatic logic [23:0] rand_credit();
    logic [31:0] r;
    r = stim_rand();
    return {4'h0, r[19:0]};
  endfunction

  // Called 1 unit after a rising edge, returns 1 unit after the edge that took the beat
  task automatic send_beat(input int lane, input logic [31:0] data, input logic last,
                           input logic [3:0] user, input logic [3:0] keep);
    logic taken;
    s_axis_tdata_i[lane*32 +: 32] = data;
    s_axis_tkeep_i[lane*4 +: 4]   = keep;
    s_axis_tlast_i[lane]          = last;
    s_axis_tuser_i[lane*4 +: 4]   = user;
    s_axis_tvalid_i[lane]         = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = s_axis_tready_o[lane];
      @(posedge clk_i);
    end
    #1;
    s_axis_tvalid_i[lane] = 1'b0;
  endtask

  task automatic send_tlp(input logic [11:0] seq, input int kind);
    logic [13:0] reply;
    logic [31:0] crc;
    logic [31:0] word;
    logic        active;
    int          len;
    active = link_status_i == pcie_datalink_pkg::DL_ACTIVE;
    reply  = tlp_reply(seq, model_seq, kind != K_GOOD);
    len    = 1 + int'(stim_rand() >> 28);
    crc    = crc32_ref(32'hFFFF_FFFF, {20'h0, seq});
    send_beat(1, {20'h0, seq}, 1'b0, 4'h0, 4'hF);
    for (int i = 0; i < len; i++) begin
      word = stim_rand();
      crc  = crc32_ref(crc, word);
      if (active && reply[0]) begin
        tlp_q.push_back({i == len - 1, 4'hF, 4'h0, word});
      end
      send_beat(1, word, 1'b0, (kind == K_PHYERR && i == 0) ? 4'h1 : 4'h0, 4'hF);
    end
    if (active) begin
      expect_dllp(reply[13] ? 8'h00 : 8'h10, reply[12:1]);
    end
    send_beat(1, ~crc ^ ((kind == K_BADCRC) ? 32'h1 : 32'h0), 1'b1, 4'h0, 4'hF);
    if (active && reply[0]) begin
      model_seq = model_seq + 12'd1;
    end
  endtask

  task automatic check_fc();
    @(negedge clk_i);
    if ({fc1_values_stored_o, fc2_values_stored_o, tx_fc_ph_o, tx_fc_pd_o, tx_fc_nph_o,
         tx_fc_npd_o} != {&fc1_seen, &fc2_seen, fc_p, fc_np}) begin
      $display("Mismatch at %0t: flow control got %h expected %h", $time,
               {fc1_values_stored_o, fc2_values_stored_o, tx_fc_ph_o, tx_fc_pd_o,
                tx_fc_nph_o, tx_fc_npd_o}, {&fc1_seen, &fc2_seen, fc_p, fc_np});
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_dllp(input logic [7:0] typ, input logic [23:0] content,
                           input logic corrupt);
    logic [31:0] word;
    word = {typ, content};
    if (phy_link_up_i && !corrupt) begin
      apply_dllp(word);
    end
    send_beat(0, word, 1'b0, 4'h0, 4'hF);
    send_beat(0, {16'h0000, crc16_ref(word) ^ {15'h0, corrupt}}, 1'b1, 4'h0, 4'b0011);
    check_fc();
  endtask

  initial begin
    rdy_seed        = 32'hc089;
    m_axis_tready_i = 2'b00;
    forever begin
      @(posedge clk_i);
      #1;
      rdy_seed        = lcg_next(rdy_seed);
      m_axis_tready_i = {rdy_seed[29:28] != 2'b00, rdy_seed[27:26] != 2'b00};
    end
  end

  always @(negedge clk_i) begin : out_compare
    logic [40:0] got;
    logic [40:0] want;
    for (int l = 0; l < 2; l++) begin
      if (!rst_i && m_axis_tvalid_o[l] && m_axis_tready_i[l]) begin
        got = {m_axis_tlast_o[l], m_axis_tkeep_o[l*4 +: 4], m_axis_tuser_o[l*4 +: 4],
               m_axis_tdata_o[l*32 +: 32]};
        if ((l == 0 && ack_q.size() == 0) || (l == 1 && tlp_q.size() == 0)) begin
          $display("Unexpected valid beat on output lane %0d at time %0t", l, $time);
          errors++;
        end else begin
          if (l == 0) begin
            want = ack_q.pop_front();
          end else begin
            want = tlp_q.pop_front();
          end
          if (got != want) begin
            $display("Mismatch at %0t: lane %0d beat got %h expected %h", $time, l, got, want);
            errors++;
          end
        end
      end
    end
  end

  always @(negedge clk_i) begin : seq_compare
    logic [12:0] want;
    if (!rst_i && seq_num_vld_o) begin
      if (seq_q.size() == 0) begin
        $display("Unexpected seq_num_vld_o pulse at time %0t", $time);
        errors++;
      end else begin
        want = seq_q.pop_front();
        if ({seq_num_acknack_o, seq_num_o} != want) begin
          $display("Mismatch at %0t: acknack and seq_num got %h expected %h", $time,
                   {seq_num_acknack_o, seq_num_o}, want);
          errors++;
        end
      end
    end
  end

  initial begin
    repeat (NUM_FRAMES * 80 + 2000) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish",
             NUM_FRAMES * 80 + 2000);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [7:0]  typ;
    rst_i           = 1'b1;
    link_status_i   = pcie_datalink_pkg::DL_ACTIVE;
    phy_link_up_i   = 1'b1;
    s_axis_tdata_i  = '0;
    s_axis_tkeep_i  = '0;
    s_axis_tvalid_i = '0;
    s_axis_tlast_i  = '0;
    s_axis_tuser_i  = '0;
    stim_seed       = 32'hc089;
    model_seq       = '0;
    fc_p            = '0;
    fc_np           = '0;
    fc1_seen        = '0;
    fc2_seen        = '0;
    errors          = 0;
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    if (m_axis_tvalid_o != 2'b00 || seq_num_vld_o || fc1_values_stored_o ||
        fc2_values_stored_o || {tx_fc_ph_o, tx_fc_pd_o, tx_fc_nph_o, tx_fc_npd_o} != '0) begin
      $display("Mismatch at %0t: outputs not cleared by reset", $time);
      errors++;
    end
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    for (int i = 0; i < N_GOOD; i++) begin
      send_tlp(model_seq, K_GOOD);
    end
    send_tlp(model_seq, K_BADCRC);
    send_tlp(model_seq, K_PHYERR);
    send_tlp(model_seq + 12'd5, K_GOOD);  // Ahead of the expected number
    send_tlp(model_seq - 12'd1, K_GOOD);  // Duplicate
    send_tlp(model_seq, K_GOOD);

    // Ack/Nak from the far end, every other one after a copy with a bad CRC
    for (int i = 0; i < N_ACKNAK; i++) begin
      r   = stim_rand();
      typ = r[31] ? pcie_datalink_pkg::DLLP_ACK : pcie_datalink_pkg::DLLP_NAK;
      if (i % 2 == 1) begin
        send_dllp(typ, {12'h000, r[11:0]}, 1'b1);
      end
      send_dllp(typ, {12'h000, r[11:0]}, 1'b0);
    end

    send_dllp(pcie_datalink_pkg::DLLP_INITFC1_P, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_INITFC1_NP, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_INITFC2_P, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_INITFC2_NP, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_UPDATEFC_P, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_UPDATEFC_NP, rand_credit(), 1'b0);
    phy_link_up_i = 1'b0;
    send_dllp(pcie_datalink_pkg::DLLP_UPDATEFC_P, rand_credit(), 1'b0);
    send_dllp(pcie_datalink_pkg::DLLP_ACK, 24'h000123, 1'b0);
    phy_link_up_i = 1'b1;

    link_status_i = pcie_datalink_pkg::DL_INIT;
    send_tlp(model_seq, K_GOOD);
    send_tlp(model_seq, K_GOOD);
    link_status_i = pcie_datalink_pkg::DL_ACTIVE;
    send_tlp(model_seq, K_GOOD);  // Still the number from before the inactive period

    repeat (NUM_FRAMES * 20) begin
      if (ack_q.size() == 0 && tlp_q.size() == 0 && seq_q.size() == 0) begin
        break;
      end
      @(posedge clk_i);
    end
    repeat (20) @(posedge clk_i);
    if (ack_q.size() != 0 || tlp_q.size() != 0 || seq_q.size() != 0) begin
      $display("Expected output never arrived: %0d Ack/Nak beats, %0d TLP beats, %0d pulses",
               ack_q.size(), tlp_q.size(), seq_q.size());
      errors++;
    end
    $display("Closing report: %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
source/pcie_datalink_pkg.sv
source/rx_tlp_fifo.sv
source/dllp_handler.sv
source/dllp2tlp.sv
source/dllp_recieve.sv
test/tb_dllp_recieve.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dllp_recieve -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
